//--- hw/sifh_consts.svh
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// bins per histogram, addresses 1 to NUM_BINS
`define SIFH_NUM_BINS 16

// bin address width
// must hold 0 (no hit) up to NUM_BINS
`define SIFH_BIN_W 5

// per-bin counter width
// counters stick at all ones
`define SIFH_COUNT_W 8

// guard bins on each side of the search window
`define SIFH_MARGIN 2

`endif

//--- hw/sifhHistPkg.sv
`include "sifh_consts.svh"

package sifhHistPkg;

    // sample bin address
    // 1-based, zero means no hit
    typedef logic [`SIFH_BIN_W-1:0] binIdx;

    // one bin's hit count
    typedef logic [`SIFH_COUNT_W-1:0] binCount;

    // histogram select
    // bit 0 coarse (CH), bit 1 fine (FH)
    // write enable on input, readout status on output
    typedef logic [1:0] histSel;

    // readout status codes
    localparam histSel SelNone = 2'b00;
    localparam histSel SelCh = 2'b01;
    localparam histSel SelFh = 2'b10;

    // builder FSM
    // acquire, then stream CH, then stream FH
    typedef enum logic [1:0] {
        ACQ,
        READ_CH,
        READ_FH
    } builderState;

endpackage

//--- hw/sifhWindowPkg.sv
`include "sifh_consts.svh"

package sifhWindowPkg;

    // bin index as a peak result, 1 to NUM_BINS
    typedef logic [`SIFH_BIN_W-1:0] peakIdx;

    // search window result
    // peaks of both histograms plus the derived thresholds
    typedef struct packed {
        // coarse histogram peak
        peakIdx peakCh;
        // fine histogram peak
        peakIdx peakFh;
        // lower bound, clamped at bin 1
        peakIdx thMinus;
        // upper bound, clamped at NUM_BINS
        peakIdx thPositive;
        // window width
        peakIdx delta;
    } window;

endpackage

//--- hw/hisBuilder.sv
`include "sifh_consts.svh"

module hisBuilder (
    input  logic                 clk,
    input  logic                 rstN,
    input  sifhHistPkg::histSel  wrEnable,
    input  logic                 acqFinish,
    input  sifhHistPkg::binIdx   addr,
    output sifhHistPkg::binCount binCounts,
    output sifhHistPkg::binIdx   rdAddr,
    output sifhHistPkg::histSel  dataFinish,
    output logic                 busy
);

    localparam sifhHistPkg::binIdx FirstBin = sifhHistPkg::binIdx'(1);
    localparam sifhHistPkg::binIdx LastBin = sifhHistPkg::binIdx'(`SIFH_NUM_BINS);
    localparam sifhHistPkg::binCount CountOne = sifhHistPkg::binCount'(1);
    localparam sifhHistPkg::binCount CountMax = '1;

    sifhHistPkg::builderState state;
    // readout pointer, walks 1..NUM_BINS per histogram
    sifhHistPkg::binIdx rdPtr;

    // bin storage, indexed by bin address
    sifhHistPkg::binCount chBins [1:`SIFH_NUM_BINS];
    sifhHistPkg::binCount fhBins [1:`SIFH_NUM_BINS];

    logic addrInRange;
    logic lastPtr;
    logic chHit;
    logic fhHit;

    // address 0 is no hit, anything past NUM_BINS is dropped too
    assign addrInRange = (addr != '0) && (addr <= LastBin);
    assign lastPtr = (rdPtr == LastBin);

    // counted only while acquiring
    // saturated bins stay put
    assign chHit = (state == sifhHistPkg::ACQ) && wrEnable[0] && addrInRange;
    assign fhHit = (state == sifhHistPkg::ACQ) && wrEnable[1] && addrInRange;

    // FSM and read pointer
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sifhHistPkg::ACQ;
            rdPtr <= FirstBin;
        end else begin
            case (state)
                sifhHistPkg::ACQ: begin
                    // finish pulse starts the readout on the next edge
                    if (acqFinish) begin
                        state <= sifhHistPkg::READ_CH;
                        rdPtr <= FirstBin;
                    end
                end
                sifhHistPkg::READ_CH: begin
                    if (lastPtr) begin
                        state <= sifhHistPkg::READ_FH;
                        rdPtr <= FirstBin;
                    end else begin
                        rdPtr <= rdPtr + FirstBin;
                    end
                end
                sifhHistPkg::READ_FH: begin
                    // back to acquiring right after the last FH bin
                    if (lastPtr) begin
                        state <= sifhHistPkg::ACQ;
                        rdPtr <= FirstBin;
                    end else begin
                        rdPtr <= rdPtr + FirstBin;
                    end
                end
                default: begin
                    state <= sifhHistPkg::ACQ;
                    rdPtr <= FirstBin;
                end
            endcase
        end
    end

    // bin counters
    // zeroed by reset and again as each bin is read out
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i <= `SIFH_NUM_BINS; i++) begin
                chBins[i] <= '0;
                fhBins[i] <= '0;
            end
        end else begin
            if (chHit && (chBins[addr] != CountMax)) begin
                chBins[addr] <= chBins[addr] + CountOne;
            end
            if (fhHit && (fhBins[addr] != CountMax)) begin
                fhBins[addr] <= fhBins[addr] + CountOne;
            end
            // clear on read
            if (state == sifhHistPkg::READ_CH) begin
                chBins[rdPtr] <= '0;
            end
            if (state == sifhHistPkg::READ_FH) begin
                fhBins[rdPtr] <= '0;
            end
        end
    end

    // readout data, qualified by dataFinish
    always_ff @(posedge clk) begin
        if (state == sifhHistPkg::READ_CH) begin
            binCounts <= chBins[rdPtr];
            rdAddr <= rdPtr;
        end else if (state == sifhHistPkg::READ_FH) begin
            binCounts <= fhBins[rdPtr];
            rdAddr <= rdPtr;
        end
    end

    // stream status, one code per histogram
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dataFinish <= sifhHistPkg::SelNone;
        end else begin
            case (state)
                sifhHistPkg::READ_CH: dataFinish <= sifhHistPkg::SelCh;
                sifhHistPkg::READ_FH: dataFinish <= sifhHistPkg::SelFh;
                default:              dataFinish <= sifhHistPkg::SelNone;
            endcase
        end
    end

    // busy spans exactly the streamed bins
    assign busy = (dataFinish != sifhHistPkg::SelNone);

    // the two histograms never stream together
    dataFinishOneHot: assert property (@(posedge clk) disable iff (!rstN)
        dataFinish != 2'b11);

    // no counting during readout
    // a bin either holds or gets cleared
    for (genvar b = 1; b <= `SIFH_NUM_BINS; b++) begin : gBinFreeze
        binsFrozen: assert property (@(posedge clk) disable iff (!rstN)
            (state != sifhHistPkg::ACQ) |=>
                ($stable(chBins[b]) || (chBins[b] == '0)) &&
                ($stable(fhBins[b]) || (fhBins[b] == '0)));
    end

endmodule

//--- hw/peakDetector.sv
`include "sifh_consts.svh"

module peakDetector (
    input  logic                  clk,
    input  logic                  rstN,
    input  sifhHistPkg::binCount  binCounts,
    input  sifhHistPkg::binIdx    rdAddr,
    input  sifhHistPkg::histSel   dataFinish,
    output sifhWindowPkg::peakIdx peakCh,
    output sifhWindowPkg::peakIdx peakFh,
    output logic                  peakValid
);

    localparam sifhHistPkg::binIdx FirstBin = sifhHistPkg::binIdx'(1);
    localparam sifhHistPkg::binIdx LastBin = sifhHistPkg::binIdx'(`SIFH_NUM_BINS);

    // running maximum over the current histogram
    sifhHistPkg::binCount runMax;
    sifhHistPkg::binIdx runIdx;
    sifhHistPkg::binCount nextMax;
    sifhHistPkg::binIdx nextIdx;

    logic binValid;
    logic restart;
    logic fhStart;
    logic lastFh;

    assign binValid = (dataFinish != sifhHistPkg::SelNone);
    // bin 1 opens each histogram
    assign restart = (rdAddr == FirstBin);
    // stream just moved to FH, running values still hold the CH result
    assign fhStart = (dataFinish == sifhHistPkg::SelFh) && restart;
    assign lastFh = (dataFinish == sifhHistPkg::SelFh) && (rdAddr == LastBin);

    // strictly greater only
    // ties keep the lower index, empty histogram keeps bin 1
    always_comb begin
        if (restart || (binCounts > runMax)) begin
            nextMax = binCounts;
            nextIdx = rdAddr;
        end else begin
            nextMax = runMax;
            nextIdx = runIdx;
        end
    end

    // search state and results
    always_ff @(posedge clk) begin
        if (binValid) begin
            runMax <= nextMax;
            runIdx <= nextIdx;
        end
        if (fhStart) begin
            peakCh <= sifhWindowPkg::peakIdx'(runIdx);
        end
        // last FH bin still has to be folded in
        if (lastFh) begin
            peakFh <= sifhWindowPkg::peakIdx'(nextIdx);
        end
    end

    // one cycle after the last FH bin
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= lastFh;
        end
    end

    // result only lands once the builder has stopped streaming
    peakAfterStream: assert property (@(posedge clk) disable iff (!rstN)
        peakValid |-> (dataFinish == sifhHistPkg::SelNone));

endmodule

//--- hw/thresholdWindow.sv
`include "sifh_consts.svh"

module thresholdWindow (
    input  logic                  clk,
    input  logic                  rstN,
    input  sifhWindowPkg::peakIdx peakCh,
    input  sifhWindowPkg::peakIdx peakFh,
    input  logic                  peakValid,
    output sifhWindowPkg::window  win,
    output logic                  winValid
);

    localparam sifhWindowPkg::peakIdx Margin = sifhWindowPkg::peakIdx'(`SIFH_MARGIN);
    localparam sifhWindowPkg::peakIdx FirstBin = sifhWindowPkg::peakIdx'(1);
    localparam sifhWindowPkg::peakIdx LastBin = sifhWindowPkg::peakIdx'(`SIFH_NUM_BINS);

    sifhWindowPkg::peakIdx lowPeak;
    sifhWindowPkg::peakIdx highPeak;
    sifhWindowPkg::peakIdx thLow;
    sifhWindowPkg::peakIdx thHigh;
    // one extra bit so peak plus margin cannot wrap
    logic [`SIFH_BIN_W:0] highSum;
    sifhWindowPkg::window winNext;

    always_comb begin
        // order the two peaks
        if (peakCh <= peakFh) begin
            lowPeak = peakCh;
            highPeak = peakFh;
        end else begin
            lowPeak = peakFh;
            highPeak = peakCh;
        end
        // lower edge, clamp at bin 1
        thLow = (lowPeak > Margin) ? (lowPeak - Margin) : FirstBin;
        // upper edge, clamp at last bin
        highSum = {1'b0, highPeak} + {1'b0, Margin};
        thHigh = (highSum > {1'b0, LastBin}) ? LastBin : highSum[`SIFH_BIN_W-1:0];
        winNext.peakCh = peakCh;
        winNext.peakFh = peakFh;
        winNext.thMinus = thLow;
        winNext.thPositive = thHigh;
        winNext.delta = thHigh - thLow;
    end

    // win holds until the next peak result
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            win <= '0;
            winValid <= 1'b0;
        end else begin
            winValid <= peakValid;
            if (peakValid) begin
                win <= winNext;
            end
        end
    end

    // clamping must never invert the window
    windowOrdered: assert property (@(posedge clk) disable iff (!rstN)
        winValid |-> (win.thMinus <= win.thPositive));

endmodule

//--- hw/sifhPeakTop.sv
module sifhPeakTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  sifhHistPkg::histSel  wrEnable,
    input  logic                 acqFinish,
    input  sifhHistPkg::binIdx   addr,
    output sifhWindowPkg::window win,
    output logic                 winValid,
    output logic                 busy
);

    // builder to detector, one bin per cycle
    sifhHistPkg::binCount binCounts;
    sifhHistPkg::binIdx rdAddr;
    sifhHistPkg::histSel dataFinish;

    // detector to window stage
    sifhWindowPkg::peakIdx peakCh;
    sifhWindowPkg::peakIdx peakFh;
    logic peakValid;

    // accumulate both histograms, stream them out on acqFinish
    hisBuilder u_hisBuilder (
        .clk        (clk),
        .rstN       (rstN),
        .wrEnable   (wrEnable),
        .acqFinish  (acqFinish),
        .addr       (addr),
        .binCounts  (binCounts),
        .rdAddr     (rdAddr),
        .dataFinish (dataFinish),
        .busy       (busy)
    );

    // largest bin of CH and FH
    peakDetector u_peakDetector (
        .clk        (clk),
        .rstN       (rstN),
        .binCounts  (binCounts),
        .rdAddr     (rdAddr),
        .dataFinish (dataFinish),
        .peakCh     (peakCh),
        .peakFh     (peakFh),
        .peakValid  (peakValid)
    );

    // peaks to clamped search window
    thresholdWindow u_thresholdWindow (
        .clk        (clk),
        .rstN       (rstN),
        .peakCh     (peakCh),
        .peakFh     (peakFh),
        .peakValid  (peakValid),
        .win        (win),
        .winValid   (winValid)
    );

endmodule

//--- bench/sifhPeakModel.sv
`include "sifh_consts.svh"

module sifhPeakModel (
    input  logic                 clk,
    input  logic                 rstN,
    input  sifhHistPkg::histSel  wrEnable,
    input  logic                 acqFinish,
    input  sifhHistPkg::binIdx   addr,
    output sifhWindowPkg::window expWin,
    output logic                 expWinValid,
    output logic                 expBusy,
    output int                   predCount
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumBins = `SIFH_NUM_BINS;
    localparam int CountMax = (1 << `SIFH_COUNT_W) - 1;
    localparam int ReadCycles = 2 * NumBins;
    // finish sample edge to window pulse
    localparam int WinLatency = 2 * NumBins + 2;

    int chHist [1:NumBins];
    int fhHist [1:NumBins];
    // edges left in the readout, samples there are dropped
    int blankLeft;
    int cycle;
    // predicted windows waiting for their due edge
    sifhWindowPkg::window pendWin [$];
    int pendDue [$];

    function automatic void clearHists();
        for (int i = 1; i <= NumBins; i++) begin
            chHist[i] = 0;
            fhHist[i] = 0;
        end
    endfunction

    // address 0 never counts, counters stick at the top
    function automatic void countSample();
        int a;
        a = int'(addr);
        if (a >= 1 && a <= NumBins) begin
            if (wrEnable[0] && chHist[a] < CountMax) begin
                chHist[a] = chHist[a] + 1;
            end
            if (wrEnable[1] && fhHist[a] < CountMax) begin
                fhHist[a] = fhHist[a] + 1;
            end
        end
    endfunction

    // largest bin, lowest index on ties, bin 1 when empty
    function automatic int peakOf(input bit fine);
        int best;
        int bestCount;
        int c;
        best = 1;
        bestCount = fine ? fhHist[1] : chHist[1];
        for (int i = 2; i <= NumBins; i++) begin
            c = fine ? fhHist[i] : chHist[i];
            if (c > bestCount) begin
                best = i;
                bestCount = c;
            end
        end
        return best;
    endfunction

    function automatic sifhWindowPkg::window predictWindow();
        sifhWindowPkg::window w;
        int pCh;
        int pFh;
        int lo;
        int hi;
        int thLo;
        int thHi;
        pCh = peakOf(1'b0);
        pFh = peakOf(1'b1);
        lo = (pCh < pFh) ? pCh : pFh;
        hi = (pCh < pFh) ? pFh : pCh;
        // guard margin, then clamp into 1..NUM_BINS
        thLo = lo - `SIFH_MARGIN;
        if (thLo < 1) begin
            thLo = 1;
        end
        thHi = hi + `SIFH_MARGIN;
        if (thHi > NumBins) begin
            thHi = NumBins;
        end
        w.peakCh = sifhWindowPkg::peakIdx'(pCh);
        w.peakFh = sifhWindowPkg::peakIdx'(pFh);
        w.thMinus = sifhWindowPkg::peakIdx'(thLo);
        w.thPositive = sifhWindowPkg::peakIdx'(thHi);
        w.delta = sifhWindowPkg::peakIdx'(thHi - thLo);
        return w;
    endfunction

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clearHists();
            blankLeft = 0;
            cycle = 0;
            pendWin.delete();
            pendDue.delete();
            expWin <= '0;
            expWinValid <= 1'b0;
            expBusy <= 1'b0;
            predCount <= 0;
        end else begin
            cycle = cycle + 1;
            // busy follows the readout one edge behind the finish
            expBusy <= (blankLeft != 0);
            if (blankLeft == 0) begin
                // the finish sample itself still counts
                countSample();
                if (acqFinish) begin
                    pendWin.push_back(predictWindow());
                    pendDue.push_back(cycle + WinLatency);
                    clearHists();
                    blankLeft = ReadCycles;
                    predCount <= predCount + 1;
                end
            end else begin
                blankLeft = blankLeft - 1;
            end
            expWinValid <= 1'b0;
            if (pendDue.size() > 0 && pendDue[0] == cycle) begin
                expWinValid <= 1'b1;
                expWin <= pendWin.pop_front();
                void'(pendDue.pop_front());
            end
        end
    end

endmodule

//--- bench/sifhPeakTb.sv
`include "sifh_consts.svh"

module sifhPeakTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumBins = `SIFH_NUM_BINS;
    localparam int ClkPeriod = 40;
    localparam int NumAcq = 20;
    // saturation pattern is the longest acquisition
    localparam int MaxAcqLen = 320;
    localparam int ReadCycles = 2 * NumBins;
    localparam int WinLatency = 2 * NumBins + 2;
    localparam int WaitLimit = WinLatency + 8;
    localparam int WatchdogCycles = NumAcq * (MaxAcqLen + 2 * NumBins + 4) + 50;

    logic clk;
    logic rstN;
    sifhHistPkg::histSel wrEnable;
    logic acqFinish;
    sifhHistPkg::binIdx addr;
    sifhWindowPkg::window win;
    logic winValid;
    logic busy;

    sifhWindowPkg::window expWin;
    logic expWinValid;
    logic expBusy;
    int predCount;

    int valueErrs;
    int otherErrs;
    int checkCount;
    int winSeen;
    int seedDummy;

    sifhPeakTop u_sifhPeakTop (
        .clk       (clk),
        .rstN      (rstN),
        .wrEnable  (wrEnable),
        .acqFinish (acqFinish),
        .addr      (addr),
        .win       (win),
        .winValid  (winValid),
        .busy      (busy)
    );

    // reference sees the same pins as the DUT
    sifhPeakModel u_model (
        .clk         (clk),
        .rstN        (rstN),
        .wrEnable    (wrEnable),
        .acqFinish   (acqFinish),
        .addr        (addr),
        .expWin      (expWin),
        .expWinValid (expWinValid),
        .expBusy     (expBusy),
        .predCount   (predCount)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic compareValue(input string name, input int expVal, input int gotVal);
        checkCount++;
        if (expVal != gotVal) begin
            $display("ERR t=%0t %s expected=%0d actual=%0d", $time, name, expVal, gotVal);
            valueErrs++;
        end
    endtask

    function automatic sifhHistPkg::histSel randomSel();
        return sifhHistPkg::histSel'($urandom_range(0, 3));
    endfunction

    // includes address 0
    function automatic sifhHistPkg::binIdx randomAddr();
        return sifhHistPkg::binIdx'($urandom_range(0, NumBins));
    endfunction

    task automatic driveSample(input sifhHistPkg::histSel we, input sifhHistPkg::binIdx a);
        @(posedge clk);
        wrEnable <= we;
        addr <= a;
        acqFinish <= 1'b0;
    endtask

    task automatic driveHits(input sifhHistPkg::histSel we, input int bin, input int n);
        repeat (n) driveSample(we, sifhHistPkg::binIdx'(bin));
    endtask

    task automatic driveRandomSamples(input int n);
        repeat (n) driveSample(randomSel(), randomAddr());
    endtask

    // finish pulse, junk during readout, then wait for the window
    task automatic finishAcquisition();
        int waited;
        int busyCycles;
        bit seen;
        waited = 0;
        busyCycles = 0;
        seen = 1'b0;
        @(posedge clk);
        wrEnable <= '0;
        addr <= '0;
        acqFinish <= 1'b1;
        while (!seen && waited < WaitLimit) begin
            @(posedge clk);
            waited++;
            if (waited <= ReadCycles) begin
                // sampled while the builder streams, all of it dropped
                wrEnable <= randomSel();
                addr <= randomAddr();
                acqFinish <= 1'($urandom_range(0, 1));
            end else begin
                wrEnable <= '0;
                addr <= '0;
                acqFinish <= 1'b0;
            end
            @(negedge clk);
            if (busy) begin
                busyCycles++;
            end
            if (winValid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("no winValid within %0d cycles of the acquisition finish", WaitLimit);
            otherErrs++;
        end else begin
            // first loop pass is the finish sample edge
            compareValue("winValid latency", WinLatency, waited - 1);
            compareValue("busy high cycles", ReadCycles, busyCycles);
        end
    endtask

    // per-cycle compare, outputs settled at the falling edge
    always @(negedge clk) begin
        compareValue("busy", expBusy, busy);
        compareValue("winValid", expWinValid, winValid);
        compareValue("win.peakCh", expWin.peakCh, win.peakCh);
        compareValue("win.peakFh", expWin.peakFh, win.peakFh);
        compareValue("win.thMinus", expWin.thMinus, win.thMinus);
        compareValue("win.thPositive", expWin.thPositive, win.thPositive);
        compareValue("win.delta", expWin.delta, win.delta);
        if (winValid) begin
            winSeen++;
        end
    end

    initial begin
        rstN = 1'b0;
        wrEnable = '0;
        acqFinish = 1'b0;
        addr = '0;
        valueErrs = 0;
        otherErrs = 0;
        checkCount = 0;
        winSeen = 0;
        seedDummy = $urandom(32'h7702);
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        // idle outputs straight out of reset
        compareValue("busy", 0, busy);
        compareValue("winValid", 0, winValid);
        compareValue("win", 0, int'(win));
        for (int i = 0; i < NumAcq; i++) begin
            case (i)
                1: begin
                    // nothing counted, both peaks fall back to bin 1
                    repeat (20) driveSample('0, randomAddr());
                    repeat (20) driveSample(randomSel(), '0);
                end
                2: begin
                    // well past 255 hits on one bin
                    driveHits(2'b11, 7, 300);
                    driveRandomSamples(20);
                end
                4: begin
                    // ties, lower index has to win
                    driveHits(2'b01, 11, 6);
                    driveHits(2'b01, 5, 6);
                    driveHits(2'b01, 7, 5);
                    driveHits(2'b10, 9, 4);
                    driveHits(2'b10, 3, 4);
                end
                5: begin
                    // peaks at both ends
                    driveHits(2'b01, 1, 10);
                    driveHits(2'b10, NumBins, 10);
                end
                6: begin
                    // margin lands exactly on the ends
                    driveHits(2'b01, 3, 5);
                    driveHits(2'b10, NumBins - 2, 5);
                end
                7: begin
                    driveHits(2'b11, 8, 12);
                    driveRandomSamples(8);
                end
                default: begin
                    driveRandomSamples($urandom_range(20, 200));
                end
            endcase
            finishAcquisition();
        end
        repeat (4) @(posedge clk);
        if (winSeen != NumAcq) begin
            $display("saw %0d windows but ran %0d acquisitions", winSeen, NumAcq);
            otherErrs++;
        end
        if (predCount != NumAcq) begin
            $display("model predicted %0d windows instead of %0d", predCount, NumAcq);
            otherErrs++;
        end
        $display("checks=%0d value errors=%0d other errors=%0d",
                 checkCount, valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // upper bound from the longest acquisition plus readout
    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("run did not finish within %0d clock cycles, stopped", WatchdogCycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/sifhHistPkg.sv
hw/sifhWindowPkg.sv
hw/hisBuilder.sv
hw/peakDetector.sv
hw/thresholdWindow.sv
hw/sifhPeakTop.sv
bench/sifhPeakModel.sv
bench/sifhPeakTb.sv
